// ==== hw/cache_pkg.sv ====
// cache subsystem package with geometry, opcodes, controller states and set layout
package cache_pkg;

    localparam int addr_w    = 12; // byte address, 4 KiB
    localparam int word_w    = 32;
    localparam int line_w    = 64; // two words per line
    localparam int sets      = 16;
    localparam int index_lsb = 3;
    localparam int index_msb = 6;
    localparam int tag_lsb   = 7;
    localparam int tag_msb   = 11;

    localparam int mem_lines = 512;
    localparam int mem_delay = 3;  // cycles from req sampled to ack
    localparam int mem_cnt_w = $clog2(mem_delay + 1);

    typedef enum logic [1:0] {
        op_read       = 2'd0,
        op_write_word = 2'd1,
        op_write_byte = 2'd2  // low byte of wdata to the addressed byte
    } mem_op_e;

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_mem_wait,
        s_respond,
        s_release
    } cache_state_e;

    typedef enum logic {
        arb_free,
        arb_busy
    } arb_state_e;

    typedef struct packed {
        logic                     valid;
        logic [tag_msb-tag_lsb:0] tag;
        logic [line_w-1:0]        data;
    } cache_way_t;

    typedef struct packed {
        cache_way_t [1:0] way;
        logic             lru; // way to replace next
    } cache_set_t;

endpackage

// ==== hw/mem_bus_if.sv ====
// four-phase req/ack memory bus between caches, arbiter and main memory
`timescale 1ns/1ps

interface mem_bus_if
    import cache_pkg::*;
();

    logic                req;
    logic                ack;
    mem_op_e             op;
    logic [addr_w-1:0]   addr;  // line address on reads, word address on writes
    logic [word_w-1:0]   wdata;
    logic [word_w/8-1:0] be;
    logic [line_w-1:0]   rdata; // valid while ack high

    modport requester (
        output req,
        output op,
        output addr,
        output wdata,
        output be,
        input  ack,
        input  rdata
    );

    modport responder (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        input  be,
        output ack,
        output rdata
    );

endinterface

// ==== hw/wt_cache.sv ====
// two-way set-associative write-through cache, one lru bit per set, no write allocate
`timescale 1ns/1ps

module wt_cache
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cpu_req,
    input  mem_op_e           cpu_op,
    input  logic [addr_w-1:0] cpu_addr,
    input  logic [word_w-1:0] cpu_wdata,
    output logic              cpu_ack,
    output logic [word_w-1:0] cpu_rdata,
    mem_bus_if.requester      mem
);

    cache_set_t   set_q [sets];
    cache_state_e state_q;

    mem_op_e             op_q;
    logic [addr_w-1:0]   addr_q;
    logic [word_w-1:0]   wdata_q;
    logic                mem_req_q;
    logic                hit_q;
    logic                hit_way_q;

    logic [index_msb-index_lsb:0] idx;
    logic [tag_msb-tag_lsb:0]     tag;
    cache_set_t                   cur_set;
    logic                         hit0;
    logic                         hit1;
    logic                         hit;
    logic                         hit_way;
    logic [word_w/8-1:0]          byte_en;

    assign idx     = addr_q[index_msb:index_lsb];
    assign tag     = addr_q[tag_msb:tag_lsb];
    assign cur_set = set_q[idx];

    assign hit0    = cur_set.way[0].valid && (cur_set.way[0].tag == tag);
    assign hit1    = cur_set.way[1].valid && (cur_set.way[1].tag == tag);
    assign hit     = hit0 || hit1;
    assign hit_way = !hit0; // only meaningful with hit set

    // byte write picks one lane from the low address bits
    assign byte_en = (op_q == op_write_byte) ? (4'b0001 << addr_q[1:0]) : 4'b1111;

    // request fields come straight from the latched cpu request
    assign mem.req   = mem_req_q;
    assign mem.op    = op_q;
    assign mem.addr  = (op_q == op_read) ? {addr_q[addr_w-1:3], 3'b000}
                                         : {addr_q[addr_w-1:2], 2'b00};
    assign mem.wdata = (op_q == op_write_byte) ? {4{wdata_q[7:0]}} : wdata_q;
    assign mem.be    = byte_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= s_idle;
            cpu_ack   <= 1'b0;
            cpu_rdata <= '0;
            mem_req_q <= 1'b0;
            hit_q     <= 1'b0;
            hit_way_q <= 1'b0;
            op_q      <= op_read;
            addr_q    <= '0;
            wdata_q   <= '0;
            for (int i = 0; i < sets; i++) begin
                set_q[i] <= '0; // all ways invalid, lru on way 0
            end
        end else begin
            case (state_q)
                s_idle: begin
                    if (cpu_req) begin
                        op_q    <= cpu_op;
                        addr_q  <= cpu_addr;
                        wdata_q <= cpu_wdata;
                        state_q <= s_lookup;
                    end
                end

                s_lookup: begin
                    hit_q     <= hit;
                    hit_way_q <= hit_way;
                    if (op_q == op_read && hit) begin
                        cpu_rdata        <= addr_q[2] ? cur_set.way[hit_way].data[63:32]
                                                      : cur_set.way[hit_way].data[31:0];
                        set_q[idx].lru   <= !hit_way; // other way is now the victim
                        state_q          <= s_respond;
                    end else begin
                        // read miss or any write goes out to memory
                        mem_req_q <= 1'b1;
                        state_q   <= s_mem_wait;
                    end
                end

                s_mem_wait: begin
                    if (mem.ack) begin
                        mem_req_q <= 1'b0;
                        if (op_q == op_read) begin
                            set_q[idx].way[cur_set.lru].valid <= 1'b1;
                            set_q[idx].way[cur_set.lru].tag   <= tag;
                            set_q[idx].way[cur_set.lru].data  <= mem.rdata;
                            set_q[idx].lru                    <= !cur_set.lru;
                            cpu_rdata <= addr_q[2] ? mem.rdata[63:32] : mem.rdata[31:0];
                        end else if (hit_q) begin
                            // keep the cached copy in step with memory
                            for (int b = 0; b < word_w / 8; b++) begin
                                if (byte_en[b]) begin
                                    set_q[idx].way[hit_way_q].data[int'(addr_q[2]) * word_w
                                        + b * 8 +: 8] <= mem.wdata[b*8 +: 8];
                                end
                            end
                        end
                        state_q <= s_respond;
                    end
                end

                s_respond: begin
                    cpu_ack <= 1'b1;
                    state_q <= s_release;
                end

                s_release: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state_q <= s_idle;
                    end
                end

                default: state_q <= s_idle;
            endcase
        end
    end

endmodule

// ==== hw/bus_arbiter.sv ====
// round-robin arbiter for two caches, grant held for a whole four-phase exchange
`timescale 1ns/1ps

module bus_arbiter
    import cache_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    mem_bus_if.responder  c0,
    mem_bus_if.responder  c1,
    mem_bus_if.requester  mem
);

    arb_state_e state_q;
    logic       gnt_q;   // cache holding the bus
    logic       last_q;  // cache served last
    logic       acked_q; // memory ack seen in this exchange
    logic       granted;
    logic       pick;

    assign granted = (state_q == arb_busy);

    // both pending means the one not served last
    assign pick = (c0.req && c1.req) ? !last_q : c1.req;

    always_comb begin
        mem.req   = 1'b0;
        mem.op    = gnt_q ? c1.op    : c0.op;
        mem.addr  = gnt_q ? c1.addr  : c0.addr;
        mem.wdata = gnt_q ? c1.wdata : c0.wdata;
        mem.be    = gnt_q ? c1.be    : c0.be;
        c0.ack    = 1'b0;
        c1.ack    = 1'b0;
        c0.rdata  = '0;
        c1.rdata  = '0;
        if (granted) begin
            if (gnt_q) begin
                mem.req  = c1.req;
                c1.ack   = mem.ack;
                c1.rdata = mem.rdata;
            end else begin
                mem.req  = c0.req;
                c0.ack   = mem.ack;
                c0.rdata = mem.rdata;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= arb_free;
            gnt_q   <= 1'b0;
            last_q  <= 1'b1; // cache 0 first
            acked_q <= 1'b0;
        end else begin
            case (state_q)
                arb_free: begin
                    if (c0.req || c1.req) begin
                        gnt_q   <= pick;
                        acked_q <= 1'b0;
                        state_q <= arb_busy;
                    end
                end
                arb_busy: begin
                    if (mem.ack) begin
                        acked_q <= 1'b1;
                    end else if (acked_q) begin
                        // ack has fallen, exchange complete
                        last_q  <= gnt_q;
                        state_q <= arb_free;
                    end
                end
                default: state_q <= arb_free;
            endcase
        end
    end

endmodule

// ==== hw/line_memory.sv ====
// main memory with line reads and byte-enabled word writes after a fixed delay
`timescale 1ns/1ps

module line_memory
    import cache_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    mem_bus_if.responder  bus
);

    // starts at zero in simulation
    logic [line_w-1:0] mem_q [mem_lines] = '{default: '0};

    logic [mem_cnt_w-1:0]         cnt_q;
    logic                         ack_q;
    logic [line_w-1:0]            rdata_q;
    logic [$clog2(mem_lines)-1:0] line_idx;
    logic                         half;
    logic                         access;

    assign line_idx = bus.addr[addr_w-1:3];
    assign half     = bus.addr[2];  // word within the line
    assign access   = bus.req && !ack_q && (cnt_q == mem_cnt_w'(mem_delay));

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
            ack_q <= 1'b0;
        end else if (access) begin
            cnt_q <= '0;
            ack_q <= 1'b1;
        end else if (bus.req && !ack_q) begin
            cnt_q <= cnt_q + 1'b1;
        end else if (ack_q && !bus.req) begin
            ack_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.op == op_read) begin
                rdata_q <= mem_q[line_idx];
            end else begin
                for (int b = 0; b < word_w / 8; b++) begin
                    if (bus.be[b]) begin
                        mem_q[line_idx][int'(half) * word_w + b * 8 +: 8] <= bus.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== hw/cache_subsys.sv ====
// two-port memory subsystem with private write-through caches on one shared memory
`timescale 1ns/1ps

module cache_subsys
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    input  logic              p0_req,
    input  mem_op_e           p0_op,
    input  logic [addr_w-1:0] p0_addr,
    input  logic [word_w-1:0] p0_wdata,
    output logic              p0_ack,
    output logic [word_w-1:0] p0_rdata,

    input  logic              p1_req,
    input  mem_op_e           p1_op,
    input  logic [addr_w-1:0] p1_addr,
    input  logic [word_w-1:0] p1_wdata,
    output logic              p1_ack,
    output logic [word_w-1:0] p1_rdata
);

    mem_bus_if c0_bus ();
    mem_bus_if c1_bus ();
    mem_bus_if m_bus  ();

    wt_cache cache0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (p0_req),
        .cpu_op    (p0_op),
        .cpu_addr  (p0_addr),
        .cpu_wdata (p0_wdata),
        .cpu_ack   (p0_ack),
        .cpu_rdata (p0_rdata),
        .mem       (c0_bus.requester)
    );

    wt_cache cache1 (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (p1_req),
        .cpu_op    (p1_op),
        .cpu_addr  (p1_addr),
        .cpu_wdata (p1_wdata),
        .cpu_ack   (p1_ack),
        .cpu_rdata (p1_rdata),
        .mem       (c1_bus.requester)
    );

    // caches share memory through one grant
    bus_arbiter arbiter (
        .clk    (clk),
        .arst_n (arst_n),
        .c0     (c0_bus.responder),
        .c1     (c1_bus.responder),
        .mem    (m_bus.requester)
    );

    line_memory memory (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (m_bus.responder)
    );

endmodule

// ==== bench/cache_subsys_asserts.sv ====
// handshake and grant checks for the cache subsystem, bound into the top level
`timescale 1ns/1ps

module cache_subsys_asserts (
    input logic clk,
    input logic arst_n,
    input logic p0_req,
    input logic p0_ack,
    input logic p1_req,
    input logic p1_ack,
    input logic c0_req,
    input logic c0_ack,
    input logic c1_req,
    input logic c1_ack,
    input logic m_req,
    input logic m_ack,
    input logic granted
);

    int unsigned fail_count = 0; // read by the testbench at the end

    function automatic void note_failure(input string what);
        $error("%s", what);
        fail_count++;
    endfunction

    // ack only answers a req that was high at the edge it rose on
    assert property (@(posedge clk) disable iff (!arst_n) $rose(p0_ack) |-> $past(p0_req))
        else note_failure("p0_ack rose without p0_req");
    assert property (@(posedge clk) disable iff (!arst_n) $rose(p1_ack) |-> $past(p1_req))
        else note_failure("p1_ack rose without p1_req");
    assert property (@(posedge clk) disable iff (!arst_n) $rose(m_ack) |-> $past(m_req))
        else note_failure("memory ack rose without memory req");

    // caches hold req until the arbiter passes ack back
    assert property (@(posedge clk) disable iff (!arst_n) c0_req && !c0_ack |=> c0_req)
        else note_failure("cache 0 dropped req before ack");
    assert property (@(posedge clk) disable iff (!arst_n) c1_req && !c1_ack |=> c1_req)
        else note_failure("cache 1 dropped req before ack");

    // grant stays until memory ack has fallen
    assert property (@(posedge clk) disable iff (!arst_n) (m_req || m_ack) |=> granted)
        else note_failure("grant released during a memory exchange");

endmodule

// ==== bench/tb_cache_subsys.sv ====
// vector-driven testbench for the two-port write-through cache subsystem
`timescale 1ns/1ps

module tb_cache_subsys
    import cache_pkg::*;
();

    localparam int          hit_cycles  = 3;   // falling edges from req up to ack on a hit
    localparam int          ack_timeout = 200;
    localparam int          row_words   = 10;  // five fields per port slot
    localparam int          max_rows    = 64;
    localparam logic [31:0] idle_op     = 32'hf;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              p0_req;
    mem_op_e           p0_op;
    logic [addr_w-1:0] p0_addr;
    logic [word_w-1:0] p0_wdata;
    logic              p0_ack;
    logic [word_w-1:0] p0_rdata;
    logic              p1_req;
    mem_op_e           p1_op;
    logic [addr_w-1:0] p1_addr;
    logic [word_w-1:0] p1_wdata;
    logic              p1_ack;
    logic [word_w-1:0] p1_rdata;

    logic [31:0] vec_mem [max_rows * row_words];
    int          seed;
    int          mismatch_count = 0;
    int          fault_count    = 0; // timeouts and missing vectors
    int          assert_count   = 0;
    bit          timed_out      = 1'b0;

    cache_subsys DUT (.*);

    bind cache_subsys cache_subsys_asserts asserts (
        .*,
        .c0_req  (c0_bus.req),
        .c0_ack  (c0_bus.ack),
        .c1_req  (c1_bus.req),
        .c1_ack  (c1_bus.ack),
        .m_req   (m_bus.req),
        .m_ack   (m_bus.ack),
        .granted (arbiter.granted)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic drive_port(input int port, input logic req, input logic [31:0] op,
                              input logic [31:0] addr, input logic [31:0] wdata);
        if (port == 0) begin
            p0_req   = req;
            p0_op    = mem_op_e'(op[1:0]);
            p0_addr  = addr[addr_w-1:0];
            p0_wdata = wdata;
        end else begin
            p1_req   = req;
            p1_op    = mem_op_e'(op[1:0]);
            p1_addr  = addr[addr_w-1:0];
            p1_wdata = wdata;
        end
    endtask

    // counts falling edges until the port ack reaches level
    task automatic wait_ack(input int port, input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (((port == 0) ? p0_ack : p1_ack) !== level && cycles < ack_timeout);
        if (((port == 0) ? p0_ack : p1_ack) !== level) begin
            $display("timeout at %0t: p%0d_ack did not go %s within %0d cycles", $time, port,
                     level ? "high" : "low", ack_timeout);
            fault_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_slot(input int port, input int base, input int gap);
        logic [31:0] op;
        int          cycles;
        string       name;
        op   = vec_mem[base];
        name = (port == 0) ? "p0" : "p1";
        if (op != idle_op) begin
            repeat (gap) @(negedge clk);
            drive_port(port, 1'b1, op, vec_mem[base+1], vec_mem[base+2]);
            wait_ack(port, 1'b1, cycles);
            if (((port == 0) ? p0_ack : p1_ack) === 1'b1) begin
                if (op[1:0] == op_read) begin
                    check_value({name, "_rdata"}, (port == 0) ? p0_rdata : p1_rdata,
                                vec_mem[base+3]);
                end
                check_value({name, "_hit"}, 32'(cycles == hit_cycles), vec_mem[base+4]);
            end
            drive_port(port, 1'b0, op, vec_mem[base+1], vec_mem[base+2]);
            wait_ack(port, 1'b0, cycles);
        end
    endtask

    initial begin
        int row;
        int gap0;
        int gap1;
        seed     = 94;
        arst_n   = 1'b0;
        p0_req   = 1'b0;
        p0_op    = op_read;
        p0_addr  = '0;
        p0_wdata = '0;
        p1_req   = 1'b0;
        p1_op    = op_read;
        p1_addr  = '0;
        p1_wdata = '0;
        for (int i = 0; i < max_rows * row_words; i++) begin
            vec_mem[i] = '1; // end marker past the last row
        end
        $readmemh("bench/cache_vectors.txt", vec_mem);

        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("p0_ack", 32'(p0_ack), 32'd0);
        check_value("p1_ack", 32'(p1_ack), 32'd0);

        row = 0;
        while (row < max_rows && vec_mem[row * row_words] != '1 && !timed_out) begin
            gap0 = $unsigned($random(seed)) % 3;
            gap1 = $unsigned($random(seed)) % 3;
            fork
                run_slot(0, row * row_words, gap0);
                run_slot(1, row * row_words + 5, gap1);
            join
            row++;
        end
        if (row == 0) begin
            $display("no vectors were read from bench/cache_vectors.txt");
            fault_count++;
        end

        assert_count = DUT.asserts.fail_count;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, fault_count, assert_count);
        if (mismatch_count + fault_count + assert_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/cache_pkg.sv
hw/mem_bus_if.sv
hw/wt_cache.sv
hw/bus_arbiter.sv
hw/line_memory.sv
hw/cache_subsys.sv
bench/cache_subsys_asserts.sv
bench/tb_cache_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cache subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_cache_subsys \
    -Mdir obj_dir -o sim_cache
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_cache +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$log"; then
    exit 1
fi
exit 0

// ==== bench/cache_vectors.txt ====
// each row holds a port 0 slot and then a port 1 slot
// slot columns are op addr wdata exp_rdata exp_hit
// op 0 read 1 write word 2 write byte f idle, exp_rdata is checked on reads only
0 010 00000000 00000000 0   0 810 00000000 00000000 0
1 020 11223344 00000000 0   1 824 55667788 00000000 0
0 020 00000000 11223344 0   0 824 00000000 55667788 0
0 020 00000000 11223344 1   0 824 00000000 55667788 1
2 022 000000ab 00000000 0   f 000 00000000 00000000 0
0 020 00000000 11ab3344 1   2 827 000000cd 00000000 0
0 0a0 00000000 00000000 0   0 824 00000000 cd667788 1
0 120 00000000 00000000 0   0 814 00000000 00000000 1
0 020 00000000 11ab3344 0   f 000 00000000 00000000 0
1 030 a0a0a0a0 00000000 0   1 830 b1b1b1b1 00000000 0
0 030 00000000 a0a0a0a0 0   0 830 00000000 b1b1b1b1 0
0 0b0 00000000 00000000 0   2 831 000000e2 00000000 0
0 130 00000000 00000000 0   0 830 00000000 b1b1e2b1 1
0 0b0 00000000 00000000 1   0 8b0 00000000 00000000 0
0 030 00000000 a0a0a0a0 0   0 930 00000000 00000000 0
0 034 00000000 00000000 1   0 830 00000000 b1b1e2b1 0
0 010 00000000 00000000 1   0 934 00000000 00000000 1
